// File: hdl/axi_bridge_defs.svh
// width and depth constants shared by the AXI to AXI-Lite subsystem
`ifndef AXI_BRIDGE_DEFS_SVH
`define AXI_BRIDGE_DEFS_SVH

// byte address width on both the AXI and the AXI-Lite side
`define AXI_ADDR_WIDTH 32

// data bus width, one strobe bit per byte of it
`define AXI_DATA_WIDTH 32

// transaction ID width on the full AXI port
`define AXI_ID_WIDTH 8

// burst length field, holding the beat count minus one
`define AXI_LEN_WIDTH 8

// number of 32-bit words in the register bank
`define REG_COUNT 16

`endif

// File: hdl/axi_bridge_pkg.sv
// common payload and response types for the AXI to AXI-Lite subsystem
`default_nettype none

`include "axi_bridge_defs.svh"

package axi_bridge_pkg;

  // one byte address
  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

  // one data word and its byte enables
  typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;

  // transaction ID, returned unchanged on B and R
  typedef logic [`AXI_ID_WIDTH-1:0] id_t;

  // burst length minus one, zero for a single beat
  typedef logic [`AXI_LEN_WIDTH-1:0] len_t;

  // response codes as encoded on the B and R channels
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

endpackage

`default_nettype wire

// File: hdl/axi_lite_write_path.sv
// write direction of the bridge, turning one AXI AW/W/B exchange into AXI-Lite
`timescale 1ns/1ps
`default_nettype none

module axi_lite_write_path (
  input  logic                  clk,
  input  logic                  rst_n,
  // AXI write address and data
  input  axi_bridge_pkg::id_t   aw_id,
  input  axi_bridge_pkg::addr_t aw_addr,
  input  axi_bridge_pkg::len_t  aw_len,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_bridge_pkg::data_t w_data,
  input  axi_bridge_pkg::strb_t w_strb,
  input  logic                  w_last,
  input  logic                  w_valid,
  output logic                  w_ready,
  // AXI write response
  output axi_bridge_pkg::id_t   b_id,
  output axi_bridge_pkg::resp_t b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,
  // AXI-Lite master side
  output axi_bridge_pkg::addr_t lite_aw_addr,
  output logic                  lite_aw_valid,
  input  logic                  lite_aw_ready,
  output axi_bridge_pkg::data_t lite_w_data,
  output axi_bridge_pkg::strb_t lite_w_strb,
  output logic                  lite_w_valid,
  input  logic                  lite_w_ready,
  input  axi_bridge_pkg::resp_t lite_b_resp,
  input  logic                  lite_b_valid,
  output logic                  lite_b_ready
);
  import axi_bridge_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_DATA, ST_LITE_REQ, ST_LITE_RESP, ST_DRAIN, ST_RESP
  } state_e;

  state_e state_q;
  // the two Lite request valids may complete on different cycles
  logic   aw_pend_q;
  logic   w_pend_q;
  id_t    id_q;
  addr_t  addr_q;
  data_t  data_q;
  strb_t  strb_q;
  resp_t  resp_q;
  logic   aw_fire;
  logic   w_fire;
  logic   b_fire;
  logic   lite_aw_fire;
  logic   lite_w_fire;
  logic   lite_b_fire;

  assign aw_fire      = aw_valid & aw_ready;
  assign w_fire       = w_valid & w_ready;
  assign b_fire       = b_valid & b_ready;
  assign lite_aw_fire = lite_aw_valid & lite_aw_ready;
  assign lite_w_fire  = lite_w_valid & lite_w_ready;
  assign lite_b_fire  = lite_b_valid & lite_b_ready;

  // a burst skips the Lite side and just swallows its data beats
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (aw_fire) state_q <= (aw_len == '0) ? ST_DATA : ST_DRAIN;
        ST_DATA: begin
          if (w_fire) begin
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
            state_q   <= ST_LITE_REQ;
          end
        end
        ST_LITE_REQ: begin
          if (lite_aw_fire) aw_pend_q <= 1'b0;
          if (lite_w_fire) w_pend_q <= 1'b0;
          // leave once the last outstanding request has gone out
          if ((lite_aw_fire || !aw_pend_q) && (lite_w_fire || !w_pend_q)) begin
            state_q <= ST_LITE_RESP;
          end
        end
        ST_LITE_RESP: if (lite_b_fire) state_q <= ST_RESP;
        ST_DRAIN: if (w_fire && w_last) state_q <= ST_RESP;
        ST_RESP: if (b_fire) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // captured request and the response to return
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= aw_id;
      addr_q <= aw_addr;
    end
    if (state_q == ST_DATA && w_fire) begin
      data_q <= w_data;
      strb_q <= w_strb;
    end
    if (lite_b_fire) begin
      resp_q <= lite_b_resp;
    end else if (state_q == ST_DRAIN && w_fire && w_last) begin
      resp_q <= RESP_SLVERR;
    end
  end

  assign aw_ready      = (state_q == ST_IDLE);
  assign w_ready       = (state_q == ST_DATA) || (state_q == ST_DRAIN);
  assign lite_aw_addr  = addr_q;
  assign lite_aw_valid = aw_pend_q;
  assign lite_w_data   = data_q;
  assign lite_w_strb   = strb_q;
  assign lite_w_valid  = w_pend_q;
  assign lite_b_ready  = (state_q == ST_LITE_RESP);
  assign b_valid       = (state_q == ST_RESP);
  assign b_id          = id_q;
  assign b_resp        = resp_q;

  // the response stays on the bus with its ID until the master takes it
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (b_valid && !b_ready) |=> (b_valid && $stable(b_id) && $stable(b_resp)));

  // the master must mark the only beat of a single-beat write as last
  a_single_last: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ST_DATA && w_fire) |-> w_last);

endmodule

`default_nettype wire

// File: hdl/axi_lite_read_path.sv
// read direction of the bridge, turning one AXI AR/R exchange into AXI-Lite
`timescale 1ns/1ps
`default_nettype none

module axi_lite_read_path (
  input  logic                  clk,
  input  logic                  rst_n,
  // AXI read address
  input  axi_bridge_pkg::id_t   ar_id,
  input  axi_bridge_pkg::addr_t ar_addr,
  input  axi_bridge_pkg::len_t  ar_len,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  // AXI read data
  output axi_bridge_pkg::id_t   r_id,
  output axi_bridge_pkg::data_t r_data,
  output axi_bridge_pkg::resp_t r_resp,
  output logic                  r_last,
  output logic                  r_valid,
  input  logic                  r_ready,
  // AXI-Lite master side
  output axi_bridge_pkg::addr_t lite_ar_addr,
  output logic                  lite_ar_valid,
  input  logic                  lite_ar_ready,
  input  axi_bridge_pkg::data_t lite_r_data,
  input  axi_bridge_pkg::resp_t lite_r_resp,
  input  logic                  lite_r_valid,
  output logic                  lite_r_ready
);
  import axi_bridge_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state_e;

  state_e state_q;
  // beats still to send after the current one
  len_t   beat_q;
  id_t    id_q;
  addr_t  addr_q;
  data_t  data_q;
  resp_t  resp_q;
  logic   ar_fire;
  logic   r_fire;
  logic   lite_ar_fire;
  logic   lite_r_fire;

  assign ar_fire      = ar_valid & ar_ready;
  assign r_fire       = r_valid & r_ready;
  assign lite_ar_fire = lite_ar_valid & lite_ar_ready;
  assign lite_r_fire  = lite_r_valid & lite_r_ready;

  // a burst goes straight to the response state and counts its error beats down
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (ar_fire) begin
            beat_q  <= ar_len;
            state_q <= (ar_len == '0) ? ST_REQ : ST_RESP;
          end
        end
        ST_REQ: if (lite_ar_fire) state_q <= ST_WAIT;
        ST_WAIT: if (lite_r_fire) state_q <= ST_RESP;
        ST_RESP: begin
          if (r_fire) begin
            if (beat_q == '0) state_q <= ST_IDLE;
            else beat_q <= beat_q - 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // a rejected burst keeps zero data and SLVERR, a forwarded read overwrites them
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= ar_id;
      addr_q <= ar_addr;
      data_q <= '0;
      resp_q <= RESP_SLVERR;
    end
    if (lite_r_fire) begin
      data_q <= lite_r_data;
      resp_q <= lite_r_resp;
    end
  end

  assign ar_ready      = (state_q == ST_IDLE);
  assign lite_ar_addr  = addr_q;
  assign lite_ar_valid = (state_q == ST_REQ);
  assign lite_r_ready  = (state_q == ST_WAIT);
  assign r_valid       = (state_q == ST_RESP);
  assign r_id          = id_q;
  assign r_data        = data_q;
  assign r_resp        = resp_q;
  assign r_last        = (beat_q == '0);

  // a stalled beat keeps every field until the master accepts it
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_id) && $stable(r_data) &&
                               $stable(r_resp) && $stable(r_last)));

endmodule

`default_nettype wire

// File: hdl/axi_to_axi_lite.sv
// AXI4 to AXI4-Lite bridge with independent write and read directions
`timescale 1ns/1ps
`default_nettype none

module axi_to_axi_lite (
  input  logic                  clk,
  input  logic                  rst_n,
  // AXI slave port
  input  axi_bridge_pkg::id_t   aw_id,
  input  axi_bridge_pkg::addr_t aw_addr,
  input  axi_bridge_pkg::len_t  aw_len,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_bridge_pkg::data_t w_data,
  input  axi_bridge_pkg::strb_t w_strb,
  input  logic                  w_last,
  input  logic                  w_valid,
  output logic                  w_ready,
  output axi_bridge_pkg::id_t   b_id,
  output axi_bridge_pkg::resp_t b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  axi_bridge_pkg::id_t   ar_id,
  input  axi_bridge_pkg::addr_t ar_addr,
  input  axi_bridge_pkg::len_t  ar_len,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output axi_bridge_pkg::id_t   r_id,
  output axi_bridge_pkg::data_t r_data,
  output axi_bridge_pkg::resp_t r_resp,
  output logic                  r_last,
  output logic                  r_valid,
  input  logic                  r_ready,
  // AXI-Lite master port
  output axi_bridge_pkg::addr_t lite_aw_addr,
  output logic                  lite_aw_valid,
  input  logic                  lite_aw_ready,
  output axi_bridge_pkg::data_t lite_w_data,
  output axi_bridge_pkg::strb_t lite_w_strb,
  output logic                  lite_w_valid,
  input  logic                  lite_w_ready,
  input  axi_bridge_pkg::resp_t lite_b_resp,
  input  logic                  lite_b_valid,
  output logic                  lite_b_ready,
  output axi_bridge_pkg::addr_t lite_ar_addr,
  output logic                  lite_ar_valid,
  input  logic                  lite_ar_ready,
  input  axi_bridge_pkg::data_t lite_r_data,
  input  axi_bridge_pkg::resp_t lite_r_resp,
  input  logic                  lite_r_valid,
  output logic                  lite_r_ready
);

  // write and read share no state, so each path runs on its own
  axi_lite_write_path wr_path0 (
    .clk, .rst_n,
    .aw_id, .aw_addr, .aw_len, .aw_valid, .aw_ready,
    .w_data, .w_strb, .w_last, .w_valid, .w_ready,
    .b_id, .b_resp, .b_valid, .b_ready,
    .lite_aw_addr, .lite_aw_valid, .lite_aw_ready,
    .lite_w_data, .lite_w_strb, .lite_w_valid, .lite_w_ready,
    .lite_b_resp, .lite_b_valid, .lite_b_ready
  );

  axi_lite_read_path rd_path0 (
    .clk, .rst_n,
    .ar_id, .ar_addr, .ar_len, .ar_valid, .ar_ready,
    .r_id, .r_data, .r_resp, .r_last, .r_valid, .r_ready,
    .lite_ar_addr, .lite_ar_valid, .lite_ar_ready,
    .lite_r_data, .lite_r_resp, .lite_r_valid, .lite_r_ready
  );

  // the Lite address and data requests start together, so one of them may
  // run alone only after the other has just been taken by the slave
  a_lite_in_step: assert property (@(posedge clk) disable iff (!rst_n)
    (lite_aw_valid ^ lite_w_valid) |->
      ($past(lite_aw_valid && lite_aw_ready) || $past(lite_w_valid && lite_w_ready) ||
       $past(lite_aw_valid ^ lite_w_valid)));

endmodule

`default_nettype wire

// File: hdl/axi_lite_regs.sv
// AXI-Lite register bank with byte strobes and decode error past the last word
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_defs.svh"

module axi_lite_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  // write address and data
  input  axi_bridge_pkg::addr_t lite_aw_addr,
  input  logic                  lite_aw_valid,
  output logic                  lite_aw_ready,
  input  axi_bridge_pkg::data_t lite_w_data,
  input  axi_bridge_pkg::strb_t lite_w_strb,
  input  logic                  lite_w_valid,
  output logic                  lite_w_ready,
  // write response
  output axi_bridge_pkg::resp_t lite_b_resp,
  output logic                  lite_b_valid,
  input  logic                  lite_b_ready,
  // read address and data
  input  axi_bridge_pkg::addr_t lite_ar_addr,
  input  logic                  lite_ar_valid,
  output logic                  lite_ar_ready,
  output axi_bridge_pkg::data_t lite_r_data,
  output axi_bridge_pkg::resp_t lite_r_resp,
  output logic                  lite_r_valid,
  input  logic                  lite_r_ready
);
  import axi_bridge_pkg::*;

  localparam int IDX_W = $clog2(`REG_COUNT);

  data_t             regs_q [`REG_COUNT];
  logic              wr_ready_q;
  logic              b_pend_q;
  logic              r_pend_q;
  resp_t             b_resp_q;
  resp_t             r_resp_q;
  data_t             r_data_q;
  logic              wr_fire;
  logic              rd_fire;
  logic              wr_in_range;
  logic              rd_in_range;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  // the word index is everything above the byte offset
  assign wr_in_range = (lite_aw_addr[`AXI_ADDR_WIDTH-1:2] < `REG_COUNT);
  assign rd_in_range = (lite_ar_addr[`AXI_ADDR_WIDTH-1:2] < `REG_COUNT);
  assign wr_idx      = lite_aw_addr[IDX_W+1:2];
  assign rd_idx      = lite_ar_addr[IDX_W+1:2];

  assign wr_fire = wr_ready_q & lite_aw_valid & lite_w_valid;
  assign rd_fire = lite_ar_valid & lite_ar_ready;

  // write ready is a one-cycle pulse once address and data are both waiting
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready_q <= 1'b0;
      b_pend_q   <= 1'b0;
      r_pend_q   <= 1'b0;
    end else begin
      wr_ready_q <= lite_aw_valid && lite_w_valid && !wr_ready_q && !b_pend_q;
      if (wr_fire) b_pend_q <= 1'b1;
      else if (lite_b_valid && lite_b_ready) b_pend_q <= 1'b0;
      if (rd_fire) r_pend_q <= 1'b1;
      else if (lite_r_valid && lite_r_ready) r_pend_q <= 1'b0;
    end
  end

  // the bank comes out of reset all zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      for (int b = 0; b < `AXI_DATA_WIDTH/8; b++) begin
        if (lite_w_strb[b]) regs_q[wr_idx][8*b +: 8] <= lite_w_data[8*b +: 8];
      end
    end
  end

  // responses and read data are captured at the request handshake
  always_ff @(posedge clk) begin
    if (wr_fire) b_resp_q <= wr_in_range ? RESP_OKAY : RESP_DECERR;
    if (rd_fire) begin
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_DECERR;
      r_data_q <= rd_in_range ? regs_q[rd_idx] : '0;
    end
  end

  assign lite_aw_ready = wr_ready_q;
  assign lite_w_ready  = wr_ready_q;
  assign lite_b_valid  = b_pend_q;
  assign lite_b_resp   = b_resp_q;
  assign lite_ar_ready = !r_pend_q;
  assign lite_r_valid  = r_pend_q;
  assign lite_r_data   = r_data_q;
  assign lite_r_resp   = r_resp_q;

  // a register only changes after a cycle that carried a full write handshake
  for (genvar g = 0; g < `REG_COUNT; g++) begin : g_wr_chk
    a_wr_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      (regs_q[g] != $past(regs_q[g])) |->
        $past(lite_aw_valid && lite_w_valid && lite_aw_ready));
  end

endmodule

`default_nettype wire

// File: hdl/axi_lite_subsystem_top.sv
// subsystem top joining the AXI to AXI-Lite bridge and the register bank
`timescale 1ns/1ps
`default_nettype none

module axi_lite_subsystem_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_bridge_pkg::id_t   aw_id,
  input  axi_bridge_pkg::addr_t aw_addr,
  input  axi_bridge_pkg::len_t  aw_len,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_bridge_pkg::data_t w_data,
  input  axi_bridge_pkg::strb_t w_strb,
  input  logic                  w_last,
  input  logic                  w_valid,
  output logic                  w_ready,
  output axi_bridge_pkg::id_t   b_id,
  output axi_bridge_pkg::resp_t b_resp,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  axi_bridge_pkg::id_t   ar_id,
  input  axi_bridge_pkg::addr_t ar_addr,
  input  axi_bridge_pkg::len_t  ar_len,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output axi_bridge_pkg::id_t   r_id,
  output axi_bridge_pkg::data_t r_data,
  output axi_bridge_pkg::resp_t r_resp,
  output logic                  r_last,
  output logic                  r_valid,
  input  logic                  r_ready
);
  import axi_bridge_pkg::*;

  // internal AXI-Lite link, bridge as master and register bank as slave
  addr_t lite_aw_addr;
  logic  lite_aw_valid, lite_aw_ready;
  data_t lite_w_data;
  strb_t lite_w_strb;
  logic  lite_w_valid, lite_w_ready;
  resp_t lite_b_resp;
  logic  lite_b_valid, lite_b_ready;
  addr_t lite_ar_addr;
  logic  lite_ar_valid, lite_ar_ready;
  data_t lite_r_data;
  resp_t lite_r_resp;
  logic  lite_r_valid, lite_r_ready;

  axi_to_axi_lite bridge0 (.*);

  axi_lite_regs regs0 (
    .clk, .rst_n,
    .lite_aw_addr, .lite_aw_valid, .lite_aw_ready,
    .lite_w_data, .lite_w_strb, .lite_w_valid, .lite_w_ready,
    .lite_b_resp, .lite_b_valid, .lite_b_ready,
    .lite_ar_addr, .lite_ar_valid, .lite_ar_ready,
    .lite_r_data, .lite_r_resp, .lite_r_valid, .lite_r_ready
  );

endmodule

`default_nettype wire

// File: tb/tb_axi_to_axi_lite.sv
// testbench for the AXI to AXI-Lite subsystem, replaying transactions from a stimulus file
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_defs.svh"

module tb_axi_to_axi_lite;
  import axi_bridge_pkg::*;

  // longest wait for any single handshake, in clock cycles
  localparam int TIMEOUT_CYCLES = 200;

  logic  clk;
  logic  rst_n;
  id_t   aw_id;
  addr_t aw_addr;
  len_t  aw_len;
  logic  aw_valid;
  logic  aw_ready;
  data_t w_data;
  strb_t w_strb;
  logic  w_last;
  logic  w_valid;
  logic  w_ready;
  id_t   b_id;
  resp_t b_resp;
  logic  b_valid;
  logic  b_ready;
  id_t   ar_id;
  addr_t ar_addr;
  len_t  ar_len;
  logic  ar_valid;
  logic  ar_ready;
  id_t   r_id;
  data_t r_data;
  resp_t r_resp;
  logic  r_last;
  logic  r_valid;
  logic  r_ready;
  logic [31:0] lfsr_q;

  axi_lite_subsystem_top dut0 (.*);

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one new bit per call
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // the response channels get fresh random back-pressure on every edge
  initial begin
    lfsr_q  = 32'h3652;
    b_ready = 1'b0;
    r_ready = 1'b0;
    forever begin
      @(posedge clk);
      b_ready <= lfsr_step();
      r_ready <= lfsr_step();
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_resp(input string test, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: resp expected %0h, actual %0h", test, exp, act));
    end
  endtask

  task automatic check_id(input string test, input id_t exp, input id_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: id expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_data(input string test, input data_t exp, input data_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: data expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_last(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: last expected %b, actual %b", test, exp, act));
    end
  endtask

  // AW and W go up together; a burst sends len+1 beats with last on the final one
  task automatic do_write(input string test, input id_t id, input addr_t addr, input len_t len,
                          input data_t data, input strb_t strb, input resp_t exp_resp);
    int   sent;
    int   cycles;
    logic aw_done;
    logic aw_hs;
    logic w_hs;
    sent    = 0;
    cycles  = 0;
    aw_done = 1'b0;
    @(posedge clk);
    aw_id    <= id;
    aw_addr  <= addr;
    aw_len   <= len;
    aw_valid <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    w_last   <= (len == '0);
    w_valid  <= 1'b1;
    while (!aw_done || sent <= int'(len)) begin
      // handshakes are judged mid-cycle, where nothing changes
      @(negedge clk);
      aw_hs = aw_valid && aw_ready;
      w_hs  = w_valid && w_ready;
      @(posedge clk);
      if (aw_hs) begin
        aw_valid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        sent++;
        if (sent > int'(len)) w_valid <= 1'b0;
        w_last <= (sent == int'(len));
      end
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure({"timeout while sending write address and data in test ", test});
      end
    end
    cycles = 0;
    @(negedge clk);
    while (!(b_valid && b_ready)) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure({"timeout while waiting for the write response in test ", test});
      end
      @(negedge clk);
    end
    check_id(test, id, b_id);
    check_resp(test, exp_resp, b_resp);
    @(posedge clk);
  endtask

  // one address beat, then len+1 data beats that are checked one by one
  task automatic do_read(input string test, input id_t id, input addr_t addr, input len_t len,
                         input resp_t exp_resp, input data_t exp_data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    ar_id    <= id;
    ar_addr  <= addr;
    ar_len   <= len;
    ar_valid <= 1'b1;
    @(negedge clk);
    while (!ar_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure({"timeout while waiting for ar_ready in test ", test});
      end
      @(negedge clk);
    end
    @(posedge clk);
    ar_valid <= 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      cycles = 0;
      @(negedge clk);
      while (!(r_valid && r_ready)) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
          report_failure({"timeout while waiting for read data in test ", test});
        end
        @(negedge clk);
      end
      check_id(test, id, r_id);
      check_resp(test, exp_resp, r_resp);
      // a decode error carries no defined data
      if (exp_resp != RESP_DECERR) check_data(test, exp_data, r_data);
      check_last(test, beat == int'(len), r_last);
      @(posedge clk);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          count;
    string       line;
    string       test;
    string       op;
    logic [31:0] f_id;
    logic [31:0] f_addr;
    logic [31:0] f_len;
    logic [31:0] f_data;
    logic [31:0] f_strb;
    logic [31:0] f_resp;
    logic [31:0] f_exp_data;
    rst_n    = 1'b0;
    aw_id    = '0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    w_valid  = 1'b0;
    ar_id    = '0;
    ar_addr  = '0;
    ar_len   = '0;
    ar_valid = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // both response channels must be quiet and both address channels open
    @(negedge clk);
    if (b_valid !== 1'b0) report_failure("b_valid is high right after reset");
    if (r_valid !== 1'b0) report_failure("r_valid is high right after reset");
    if (aw_ready !== 1'b1) report_failure("aw_ready is low right after reset");
    if (ar_ready !== 1'b1) report_failure("ar_ready is low right after reset");
    fd = $fopen("tb/axi_bridge_stim.txt", "r");
    if (fd == 0) report_failure("cannot open the stimulus file tb/axi_bridge_stim.txt");
    count = 0;
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // comment lines start with a hash, blank lines are skipped
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %s %h %h %h %h %h %h %h", test, op, f_id, f_addr, f_len,
                       f_data, f_strb, f_resp, f_exp_data);
        if (code != 9) report_failure({"malformed stimulus line: ", line});
        if (op == "W") begin
          do_write(test, id_t'(f_id), addr_t'(f_addr), len_t'(f_len), data_t'(f_data),
                   strb_t'(f_strb), resp_t'(f_resp[1:0]));
        end else if (op == "R") begin
          do_read(test, id_t'(f_id), addr_t'(f_addr), len_t'(f_len), resp_t'(f_resp[1:0]),
                  data_t'(f_exp_data));
        end else begin
          report_failure({"unknown operation in stimulus line: ", line});
        end
        count++;
      end
    end
    $fclose(fd);
    if (count == 0) begin
      report_failure("the stimulus file holds no transactions");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb/axi_bridge_stim.txt
# columns: test op(W/R) id addr len data strb exp_resp exp_data, all numbers in hex
# exp_resp 0 OKAY, 2 SLVERR, 3 DECERR; data and strb unused on reads, exp_data unused on writes
rst_r0 R 20 00000000 00 00000000 0 0 00000000
rst_r1 R 21 00000004 00 00000000 0 0 00000000
rst_r2 R 22 00000008 00 00000000 0 0 00000000
rst_r3 R 23 0000000c 00 00000000 0 0 00000000
rst_r4 R 24 00000010 00 00000000 0 0 00000000
rst_r5 R 25 00000014 00 00000000 0 0 00000000
rst_r6 R 26 00000018 00 00000000 0 0 00000000
rst_r7 R 27 0000001c 00 00000000 0 0 00000000
rst_r8 R 28 00000020 00 00000000 0 0 00000000
rst_r9 R 29 00000024 00 00000000 0 0 00000000
rst_r10 R 2a 00000028 00 00000000 0 0 00000000
rst_r11 R 2b 0000002c 00 00000000 0 0 00000000
rst_r12 R 2c 00000030 00 00000000 0 0 00000000
rst_r13 R 2d 00000034 00 00000000 0 0 00000000
rst_r14 R 2e 00000038 00 00000000 0 0 00000000
rst_r15 R 2f 0000003c 00 00000000 0 0 00000000
wr_r0 W 01 00000000 00 11223344 f 0 00000000
wr_r5 W 02 00000014 00 a5a5a5a5 f 0 00000000
wr_r15 W 03 0000003c 00 deadbeef f 0 00000000
rd_r0 R 04 00000000 00 00000000 0 0 11223344
rd_r5 R 05 00000014 00 00000000 0 0 a5a5a5a5
rd_r15 R 06 0000003c 00 00000000 0 0 deadbeef
wr_r5_strb5 W 07 00000014 00 0f0f0f0f 5 0 00000000
rd_r5_strb5 R 08 00000014 00 00000000 0 0 a50fa50f
wr_r0_strba W 09 00000000 00 99887766 a 0 00000000
rd_r0_strba R 0a 00000000 00 00000000 0 0 99227744
wr_r15_strb0 W 0b 0000003c 00 00000000 0 0 00000000
rd_r15_strb0 R 0c 0000003c 00 00000000 0 0 deadbeef
wr_oob_40 W 0d 00000040 00 ffffffff f 3 00000000
wr_oob_1000 W 0e 00001000 00 ffffffff f 3 00000000
rd_oob_40 R 0f 00000040 00 00000000 0 3 00000000
rd_oob_8000 R 10 80000000 00 00000000 0 3 00000000
rd_r0_after_oob R 11 00000000 00 00000000 0 0 99227744
wr_burst_r2 W 12 00000008 03 cafef00d f 2 00000000
wr_burst_r0 W 13 00000000 01 12345678 f 2 00000000
rd_r2_after_burst R 14 00000008 00 00000000 0 0 00000000
rd_r0_after_burst R 15 00000000 00 00000000 0 0 99227744
rd_burst4 R 16 00000000 03 00000000 0 2 00000000
rd_burst8 R 17 0000003c 07 00000000 0 2 00000000
wr_r1 W ff 00000004 00 0badc0de f 0 00000000
rd_r1 R 80 00000004 00 00000000 0 0 0badc0de
wr_r10 W 5a 00000028 00 87654321 f 0 00000000
rd_r10 R a5 00000028 00 00000000 0 0 87654321
rd_r5_final R 00 00000014 00 00000000 0 0 a50fa50f

// File: list.f
+incdir+hdl
hdl/axi_bridge_pkg.sv
hdl/axi_lite_write_path.sv
hdl/axi_lite_read_path.sv
hdl/axi_to_axi_lite.sv
hdl/axi_lite_regs.sv
hdl/axi_lite_subsystem_top.sv
tb/tb_axi_to_axi_lite.sv
